// File: design/mist_pkg.sv
/*
  shared widths, command codes and OSD window limits for the board base
  imported by each design file that uses one of them
*/
package mist_pkg;

    localparam int COLORW      = 6;     // output colour depth
    localparam int GAME_COLORW = 4;     // native game colour depth

    typedef logic [COLORW-1:0]      color_t;
    typedef logic [GAME_COLORW-1:0] game_color_t;
    typedef logic [31:0]            word_t;     // status and joystick words
    typedef logic [15:0]            pcm_t;
    typedef logic [9:0]             hpos_t;
    typedef logic [9:0]             vpos_t;
    typedef logic [7:0]             byte_t;     // one serial byte

    // commands from the I/O controller
    localparam byte_t CMD_JOY1   = 8'h01;
    localparam byte_t CMD_JOY2   = 8'h02;
    localparam byte_t CMD_CONFIG = 8'h14;
    localparam byte_t CMD_STATUS = 8'h15;

    // config byte and status word fields
    localparam int CFG_SCAN2X_DIS_BIT = 0;
    localparam int CFG_YPBPR_BIT      = 1;
    localparam int STATUS_OSD_BIT     = 0;

    // shaded OSD window, limits inclusive
    localparam hpos_t OSD_X0 = 10'd64;
    localparam hpos_t OSD_X1 = 10'd191;
    localparam vpos_t OSD_Y0 = 10'd32;
    localparam vpos_t OSD_Y1 = 10'd95;

    localparam logic SND_SIGNED = 1'b1;     // samples are two's complement

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_CMD,
        RX_DATA,
        RX_DONE
    } rx_state_t;

endpackage

// File: design/cfg_if.sv
/*
  configuration levels held by the serial receiver
  the receiver drives it through src, the video blocks read it through dst
*/
`timescale 1ns/1ns

interface cfg_if import mist_pkg::*; ();

    word_t status;
    word_t joy1;
    word_t joy2;
    logic  scan2x_dis;  // native video with composite sync
    logic  ypbpr;       // component output

    modport src (
        output status, joy1, joy2, scan2x_dis, ypbpr
    );

    modport dst (
        input status, joy1, joy2, scan2x_dis, ypbpr
    );

endinterface

// File: design/spi_cfg_rx.sv
/*
  serial command receiver for the I/O controller link
  sck, ss and di are oversampled on clk_sys; a command byte is followed by
  four data bytes (joysticks, status) or one (config), MSB first
*/
`timescale 1ns/1ns

module spi_cfg_rx import mist_pkg::*; (
    input  logic clk_sys,
    input  logic rst_i,
    input  logic spi_sck_i,
    input  logic spi_ss_i,     // active low frame
    input  logic spi_di_i,
    cfg_if.src   cfg
);

    logic [1:0]  sck_sync;
    logic [1:0]  ss_sync;
    logic [1:0]  di_sync;
    logic        sck_d;
    logic        ss_act;
    logic        bit_stb;
    logic        byte_done;
    logic [2:0]  bit_cnt;
    logic [1:0]  byte_cnt;      // data bytes left after the current one
    logic [6:0]  byte_sr;
    byte_t       rx_byte;
    byte_t       cmd_q;
    logic [23:0] data_sr;
    rx_state_t   state;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            sck_sync <= 2'b00;
            ss_sync  <= 2'b11;  // idle frame
            sck_d    <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[0], spi_sck_i};
            ss_sync  <= {ss_sync[0], spi_ss_i};
            sck_d    <= sck_sync[1];
        end
    end

    always_ff @(posedge clk_sys) begin
        di_sync <= {di_sync[0], spi_di_i};
    end

    assign ss_act    = ~ss_sync[1];
    assign bit_stb   = ss_act & sck_sync[1] & ~sck_d;     // sck rising edge
    assign byte_done = bit_stb && (bit_cnt == 3'd7);
    assign rx_byte   = {byte_sr, di_sync[1]};             // byte incl. current bit

    // bit shifter, command byte and data bytes
    always_ff @(posedge clk_sys) begin
        if (bit_stb)
            byte_sr <= rx_byte[6:0];
        if (byte_done && state == RX_CMD)
            cmd_q <= rx_byte;
        if (byte_done && state == RX_DATA)
            data_sr <= {data_sr[15:0], rx_byte};
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            state          <= RX_IDLE;
            bit_cnt        <= 3'd0;
            byte_cnt       <= 2'd0;
            cfg.status     <= '0;
            cfg.joy1       <= '0;
            cfg.joy2       <= '0;
            cfg.scan2x_dis <= 1'b0;
            cfg.ypbpr      <= 1'b0;
        end else if (!ss_act) begin
            state   <= RX_IDLE;     // partial frame data dropped
            bit_cnt <= 3'd0;
        end else begin
            if (bit_stb)
                bit_cnt <= bit_cnt + 3'd1;
            case (state)
                RX_IDLE: state <= RX_CMD;
                RX_CMD: if (byte_done) begin
                    case (rx_byte)
                        CMD_JOY1, CMD_JOY2, CMD_STATUS: begin
                            byte_cnt <= 2'd3;
                            state    <= RX_DATA;
                        end
                        CMD_CONFIG: begin
                            byte_cnt <= 2'd0;
                            state    <= RX_DATA;
                        end
                        default: state <= RX_DONE;  // unknown command ignored
                    endcase
                end
                RX_DATA: if (byte_done) begin
                    if (byte_cnt == 2'd0) begin
                        state <= RX_DONE;
                        case (cmd_q)
                            CMD_JOY1:   cfg.joy1   <= {data_sr, rx_byte};
                            CMD_JOY2:   cfg.joy2   <= {data_sr, rx_byte};
                            CMD_STATUS: cfg.status <= {data_sr, rx_byte};
                            default: begin
                                cfg.scan2x_dis <= rx_byte[CFG_SCAN2X_DIS_BIT];
                                cfg.ypbpr      <= rx_byte[CFG_YPBPR_BIT];
                            end
                        endcase
                    end else begin
                        byte_cnt <= byte_cnt - 2'd1;
                    end
                end
                RX_DONE: state <= RX_DONE;  // wait for ss to rise
                default: state <= RX_IDLE;
            endcase
        end
    end

endmodule

// File: design/video_osd_mix.sv
/*
  picks native or scan-doubled video and shades the OSD window
  native colour is widened to 6 bits and its sync inverted to active low;
  one register stage on every output
*/
`timescale 1ns/1ns

module video_osd_mix import mist_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_i,
    cfg_if.dst          cfg,
    input  game_color_t game_r_i,
    input  game_color_t game_g_i,
    input  game_color_t game_b_i,
    input  logic        hs_i,           // active high
    input  logic        vs_i,
    input  color_t      scan2x_r_i,
    input  color_t      scan2x_g_i,
    input  color_t      scan2x_b_i,
    input  logic        scan2x_hs_i,    // active low
    input  logic        scan2x_vs_i,
    output color_t      mix_r_o,
    output color_t      mix_g_o,
    output color_t      mix_b_o,
    output logic        mix_hs_o,
    output logic        mix_vs_o,
    output logic        osd_shown_o
);

    color_t sel_r;
    color_t sel_g;
    color_t sel_b;
    logic   sel_hs;
    logic   sel_vs;
    logic   hs_d;
    hpos_t  hpos;
    vpos_t  vpos;
    logic   osd_en;
    logic   in_win;
    logic   shade;

    // repeat the top bits into the new LSBs
    function automatic color_t widen(input game_color_t c);
        return {c, c[GAME_COLORW-1 -: COLORW-GAME_COLORW]};
    endfunction

    always_comb begin
        if (cfg.scan2x_dis) begin
            sel_r  = widen(game_r_i);
            sel_g  = widen(game_g_i);
            sel_b  = widen(game_b_i);
            sel_hs = ~hs_i;
            sel_vs = ~vs_i;
        end else begin
            sel_r  = scan2x_r_i;
            sel_g  = scan2x_g_i;
            sel_b  = scan2x_b_i;
            sel_hs = scan2x_hs_i;
            sel_vs = scan2x_vs_i;
        end
    end

    // first pixel after hsync sees column 0
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            hpos <= '0;
            vpos <= '0;
            hs_d <= 1'b1;
        end else begin
            hs_d <= sel_hs;
            if (!sel_hs)
                hpos <= '0;
            else
                hpos <= hpos + 10'd1;
            if (!sel_vs)
                vpos <= '0;
            else if (sel_hs && !hs_d)
                vpos <= vpos + 10'd1;   // end of hsync pulse
        end
    end

    assign osd_en = cfg.status[STATUS_OSD_BIT];
    assign in_win = (hpos >= OSD_X0) && (hpos <= OSD_X1) &&
                    (vpos >= OSD_Y0) && (vpos <= OSD_Y1);
    assign shade  = osd_en && in_win;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            mix_r_o     <= '0;
            mix_g_o     <= '0;
            mix_b_o     <= '0;
            mix_hs_o    <= 1'b0;
            mix_vs_o    <= 1'b0;
            osd_shown_o <= 1'b0;
        end else begin
            mix_r_o     <= shade ? (sel_r >> 1) : sel_r;
            mix_g_o     <= shade ? (sel_g >> 1) : sel_g;
            mix_b_o     <= shade ? {1'b1, sel_b[COLORW-1:1]} : sel_b;   // bluish tint
            mix_hs_o    <= sel_hs;
            mix_vs_o    <= sel_vs;
            osd_shown_o <= osd_en;
        end
    end

endmodule

// File: design/rgb_to_ypbpr.sv
/*
  combinational RGB to YPbPr conversion on 6-bit channels
  Y = (2R + 5G + B) / 8, Pb and Pr centred on 32
*/
`timescale 1ns/1ns

module rgb_to_ypbpr import mist_pkg::*; (
    input  color_t r_i,
    input  color_t g_i,
    input  color_t b_i,
    output color_t y_o,
    output color_t pb_o,
    output color_t pr_o
);

    logic [8:0]        y_sum;   // up to 504
    color_t            y;
    logic signed [7:0] b_diff;
    logic signed [7:0] r_diff;
    logic signed [7:0] pb_full;
    logic signed [7:0] pr_full;

    assign y_sum = (9'(r_i) << 1) + 9'(g_i) * 9'd5 + 9'(b_i);
    assign y     = y_sum[8:3];      // truncated divide by 8

    assign b_diff = $signed({2'b00, b_i}) - $signed({2'b00, y});
    assign r_diff = $signed({2'b00, r_i}) - $signed({2'b00, y});

    // arithmetic shift rounds toward minus infinity
    assign pb_full = (b_diff >>> 1) + 8'sd32;
    assign pr_full = (r_diff >>> 1) + 8'sd32;

    assign y_o  = y;
    assign pb_o = pb_full[5:0];     // always 0..63
    assign pr_o = pr_full[5:0];

endmodule

// File: design/video_out.sv
/*
  final video stage: RGB or YPbPr colour and separate or composite sync
  composite sync goes on HS with VS held high, for SCART and component use;
  all outputs registered
*/
`timescale 1ns/1ns

module video_out import mist_pkg::*; (
    input  logic   clk_sys,
    input  logic   rst_i,
    cfg_if.dst     cfg,
    input  color_t mix_r_i,
    input  color_t mix_g_i,
    input  color_t mix_b_i,
    input  logic   mix_hs_i,
    input  logic   mix_vs_i,
    output color_t video_r_o,
    output color_t video_g_o,
    output color_t video_b_o,
    output logic   video_hs_o,
    output logic   video_vs_o
);

    color_t y;
    color_t pb;
    color_t pr;
    logic   csync;
    logic   csync_mode;

    rgb_to_ypbpr u_ypbpr (
        .r_i  ( mix_r_i ),
        .g_i  ( mix_g_i ),
        .b_i  ( mix_b_i ),
        .y_o  ( y       ),
        .pb_o ( pb      ),
        .pr_o ( pr      )
    );

    assign csync      = ~(mix_hs_i ^ mix_vs_i);
    assign csync_mode = cfg.scan2x_dis | cfg.ypbpr;

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            video_r_o  <= '0;
            video_g_o  <= '0;
            video_b_o  <= '0;
            video_hs_o <= 1'b0;
            video_vs_o <= 1'b0;
        end else begin
            video_r_o  <= cfg.ypbpr ? pr : mix_r_i;
            video_g_o  <= cfg.ypbpr ? y  : mix_g_i;
            video_b_o  <= cfg.ypbpr ? pb : mix_b_i;
            video_hs_o <= csync_mode ? csync : mix_hs_i;
            video_vs_o <= csync_mode ? 1'b1  : mix_vs_i;  // VS high selects RGB on SCART
        end
    end

endmodule

// File: design/sigma_delta_dac.sv
/*
  first-order sigma-delta audio converter, one bit out per clk_sys cycle
  the sample is moved to offset binary and added to the accumulator;
  the carry of that add is the output bit
*/
`timescale 1ns/1ns

module sigma_delta_dac import mist_pkg::*; (
    input  logic clk_sys,
    input  logic rst_i,
    input  pcm_t pcm_i,
    output logic dac_o
);

    pcm_t        pcm_ofs;
    pcm_t        acc;
    logic [16:0] sum;

    // midscale for a zero signed sample
    assign pcm_ofs = {pcm_i[15] ^ SND_SIGNED, pcm_i[14:0]};
    assign sum     = {1'b0, acc} + {1'b0, pcm_ofs};

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            acc   <= '0;
            dac_o <= 1'b0;
        end else begin
            acc   <= sum[15:0];
            dac_o <= sum[16];   // overflow density tracks the level
        end
    end

endmodule

// File: design/mist_base_top.sv
/*
  board base of the arcade core, single clk_sys domain
  holds the serial config receiver, the video mixer and output stage,
  and one audio converter per channel
*/
`timescale 1ns/1ns

module mist_base_top import mist_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_i,
    // I/O controller link
    input  logic        spi_sck_i,
    input  logic        spi_ss_i,
    input  logic        spi_di_i,
    // native game video
    input  game_color_t game_r_i,
    input  game_color_t game_g_i,
    input  game_color_t game_b_i,
    input  logic        hs_i,
    input  logic        vs_i,
    // scan-doubled video
    input  color_t      scan2x_r_i,
    input  color_t      scan2x_g_i,
    input  color_t      scan2x_b_i,
    input  logic        scan2x_hs_i,
    input  logic        scan2x_vs_i,
    // audio
    input  pcm_t        snd_left_i,
    input  pcm_t        snd_right_i,
    // video out
    output color_t      video_r_o,
    output color_t      video_g_o,
    output color_t      video_b_o,
    output logic        video_hs_o,
    output logic        video_vs_o,
    output logic        snd_pwm_left_o,
    output logic        snd_pwm_right_o,
    // control
    output word_t       status_o,
    output word_t       joystick1_o,
    output word_t       joystick2_o,
    output logic        scan2x_enb_o,   // scan doubler disabled
    output logic        osd_shown_o
);

    color_t mix_r;
    color_t mix_g;
    color_t mix_b;
    logic   mix_hs;
    logic   mix_vs;

    cfg_if cfg ();

    spi_cfg_rx u_cfg_rx (
        .clk_sys   ( clk_sys   ),
        .rst_i     ( rst_i     ),
        .spi_sck_i ( spi_sck_i ),
        .spi_ss_i  ( spi_ss_i  ),
        .spi_di_i  ( spi_di_i  ),
        .cfg       ( cfg.src   )
    );

    video_osd_mix u_mix (
        .clk_sys     ( clk_sys     ),
        .rst_i       ( rst_i       ),
        .cfg         ( cfg.dst     ),
        .game_r_i    ( game_r_i    ),
        .game_g_i    ( game_g_i    ),
        .game_b_i    ( game_b_i    ),
        .hs_i        ( hs_i        ),
        .vs_i        ( vs_i        ),
        .scan2x_r_i  ( scan2x_r_i  ),
        .scan2x_g_i  ( scan2x_g_i  ),
        .scan2x_b_i  ( scan2x_b_i  ),
        .scan2x_hs_i ( scan2x_hs_i ),
        .scan2x_vs_i ( scan2x_vs_i ),
        .mix_r_o     ( mix_r       ),
        .mix_g_o     ( mix_g       ),
        .mix_b_o     ( mix_b       ),
        .mix_hs_o    ( mix_hs      ),
        .mix_vs_o    ( mix_vs      ),
        .osd_shown_o ( osd_shown_o )
    );

    video_out u_video_out (
        .clk_sys    ( clk_sys    ),
        .rst_i      ( rst_i      ),
        .cfg        ( cfg.dst    ),
        .mix_r_i    ( mix_r      ),
        .mix_g_i    ( mix_g      ),
        .mix_b_i    ( mix_b      ),
        .mix_hs_i   ( mix_hs     ),
        .mix_vs_i   ( mix_vs     ),
        .video_r_o  ( video_r_o  ),
        .video_g_o  ( video_g_o  ),
        .video_b_o  ( video_b_o  ),
        .video_hs_o ( video_hs_o ),
        .video_vs_o ( video_vs_o )
    );

    sigma_delta_dac u_dac_left (
        .clk_sys ( clk_sys        ),
        .rst_i   ( rst_i          ),
        .pcm_i   ( snd_left_i     ),
        .dac_o   ( snd_pwm_left_o )
    );

    sigma_delta_dac u_dac_right (
        .clk_sys ( clk_sys         ),
        .rst_i   ( rst_i           ),
        .pcm_i   ( snd_right_i     ),
        .dac_o   ( snd_pwm_right_o )
    );

    assign status_o     = cfg.status;
    assign joystick1_o  = cfg.joy1;
    assign joystick2_o  = cfg.joy2;
    assign scan2x_enb_o = cfg.scan2x_dis;

endmodule

// File: verif/mist_base_model.svh
/*
  reference models for the board base testbench
  config registers, selected pixel to output pixel, counters and DAC step;
  included inside the testbench module
*/
`ifndef MIST_BASE_MODEL_SVH
`define MIST_BASE_MODEL_SVH

typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
    logic   hs;     // active low after selection
    logic   vs;
} px_t;

word_t m_status     = '0;
word_t m_joy1       = '0;
word_t m_joy2       = '0;
logic  m_scan2x_dis = 1'b0;
logic  m_ypbpr      = 1'b0;
hpos_t m_hpos       = '0;
vpos_t m_vpos       = '0;
logic  m_hs_d       = 1'b1;

// only complete frames of known commands land in a register
task automatic model_frame(input byte_t cmd, input word_t data, input int nbits);
    if (cmd == CMD_CONFIG && nbits == 16) begin
        m_scan2x_dis = data[24 + CFG_SCAN2X_DIS_BIT];
        m_ypbpr      = data[24 + CFG_YPBPR_BIT];
    end else if (nbits == 40) begin
        case (cmd)
            CMD_JOY1:   m_joy1 = data;
            CMD_JOY2:   m_joy2 = data;
            CMD_STATUS: m_status = data;
            default:    ;
        endcase
    end
endtask

function automatic color_t widen_model(input game_color_t c);
    return {c, c[GAME_COLORW-1], c[GAME_COLORW-2]};
endfunction

function automatic int floor_half(input int d);
    return (d >= 0) ? d / 2 : (d - 1) / 2;
endfunction

// selected pixel in, expected video_out pixel back; steps the counters
task automatic pixel_model(input px_t sel, output px_t out);
    px_t  mix;
    int   y;
    logic shade;
    shade = m_status[STATUS_OSD_BIT] && m_hpos >= OSD_X0 && m_hpos <= OSD_X1 &&
            m_vpos >= OSD_Y0 && m_vpos <= OSD_Y1;
    mix = sel;
    if (shade) begin
        mix.r = sel.r / 2;
        mix.g = sel.g / 2;
        mix.b = 6'd32 | (sel.b / 2);
    end
    out = mix;
    if (m_ypbpr) begin
        y     = (2 * int'(mix.r) + 5 * int'(mix.g) + int'(mix.b)) / 8;
        out.g = color_t'(y);
        out.r = color_t'(32 + floor_half(int'(mix.r) - y));
        out.b = color_t'(32 + floor_half(int'(mix.b) - y));
    end
    if (m_scan2x_dis || m_ypbpr) begin
        out.hs = ~(mix.hs ^ mix.vs);    // composite
        out.vs = 1'b1;
    end
    m_hpos = sel.hs ? m_hpos + 10'd1 : '0;
    if (!sel.vs)
        m_vpos = '0;
    else if (sel.hs && !m_hs_d)
        m_vpos = m_vpos + 10'd1;
    m_hs_d = sel.hs;
endtask

// {carry, next accumulator}
function automatic logic [16:0] dac_step(input pcm_t acc, input pcm_t sample);
    pcm_t ofs;
    ofs = sample + 16'h8000;    // offset binary
    return {1'b0, acc} + {1'b0, ofs};
endfunction

`endif

// File: verif/mist_base_tb.sv
/*
  testbench for the board base top level
  drives serial config frames, video and audio from an LFSR and checks
  every result against the models in the included header
*/
`timescale 1ns/1ns

module mist_base_tb import mist_pkg::*; ();

    localparam int HALF_SCK     = 4;        // clk_sys cycles per sck phase
    localparam int FRAME_CYCLES = 40 * 2 * HALF_SCK + 20;
    localparam int CFG_FRAMES   = 20;
    localparam int VID_PIXELS   = 300;
    localparam int OSD_LINES    = 100;
    localparam int AUD_CYCLES   = 1000;
    localparam int BUDGET = (CFG_FRAMES + 10) * FRAME_CYCLES + 4 * VID_PIXELS +
                            OSD_LINES * 250 + AUD_CYCLES;
    localparam int TIMEOUT_NS = (BUDGET + 2000) * 10;

    logic        clk_sys = 1'b0;
    logic        rst_i;
    logic        spi_sck_i;
    logic        spi_ss_i;
    logic        spi_di_i;
    game_color_t game_r_i;
    game_color_t game_g_i;
    game_color_t game_b_i;
    logic        hs_i;
    logic        vs_i;
    color_t      scan2x_r_i;
    color_t      scan2x_g_i;
    color_t      scan2x_b_i;
    logic        scan2x_hs_i;
    logic        scan2x_vs_i;
    pcm_t        snd_left_i;
    pcm_t        snd_right_i;
    color_t      video_r_o;
    color_t      video_g_o;
    color_t      video_b_o;
    logic        video_hs_o;
    logic        video_vs_o;
    logic        snd_pwm_left_o;
    logic        snd_pwm_right_o;
    word_t       status_o;
    word_t       joystick1_o;
    word_t       joystick2_o;
    logic        scan2x_enb_o;
    logic        osd_shown_o;

    `include "mist_base_model.svh"

    logic [31:0] lfsr_q = 32'h31e2_0acf;
    string       test_name = "init";
    px_t         pipe[$];   // expected pixels, two stages deep
    pcm_t        acc_l;
    pcm_t        acc_r;
    logic        dac_l_exp;
    logic        dac_r_exp;

    mist_base_top UUT (.*);

    always #5 clk_sys = ~clk_sys;

    // taps 32, 22, 2, 1
    function automatic logic rand_bit();
        logic fb;
        fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[30:0], rand_bit()};
        return v;
    endfunction

    task automatic report_error();
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            report_error();
        end
    endtask

    task automatic check_color(input string what, input color_t exp, input color_t act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
            report_error();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
            report_error();
        end
    endtask

    // converter model, sees the same input values as the DUT at each edge
    always @(posedge clk_sys) begin
        if (rst_i) begin
            acc_l     = '0;
            acc_r     = '0;
            dac_l_exp = 1'b0;
            dac_r_exp = 1'b0;
        end else begin
            {dac_l_exp, acc_l} = dac_step(acc_l, snd_left_i);
            {dac_r_exp, acc_r} = dac_step(acc_r, snd_right_i);
        end
    end

    task automatic check_cfg();
        check_word("status", m_status, status_o);
        check_word("joystick1", m_joy1, joystick1_o);
        check_word("joystick2", m_joy2, joystick2_o);
        check_bit("scan2x_enb", m_scan2x_dis, scan2x_enb_o);
    endtask

    // MSB first, nbits taken from the top of bits
    task automatic send_frame(input logic [39:0] bits, input int nbits);
        @(posedge clk_sys);
        spi_ss_i <= 1'b0;
        repeat (HALF_SCK) @(posedge clk_sys);
        for (int i = 0; i < nbits; i++) begin
            spi_sck_i <= 1'b0;
            spi_di_i  <= bits[39-i];
            repeat (HALF_SCK) @(posedge clk_sys);
            spi_sck_i <= 1'b1;
            repeat (HALF_SCK) @(posedge clk_sys);
        end
        spi_sck_i <= 1'b0;
        spi_ss_i  <= 1'b1;
        repeat (4) @(posedge clk_sys);
    endtask

    task automatic apply_frame(input byte_t cmd, input word_t data, input int nbits);
        send_frame({cmd, data}, nbits);
        model_frame(cmd, data, nbits);
        pipe.delete();  // mode may have changed under the pipeline
        @(negedge clk_sys);
        check_cfg();
    endtask

    task automatic pixel_cycle(input logic hs_sel, input logic vs_sel);
        px_t         sel;
        px_t         exp;
        game_color_t gr;
        game_color_t gg;
        game_color_t gb;
        color_t      sr;
        color_t      sg;
        color_t      sb;
        logic        other_hs;
        logic        other_vs;
        @(posedge clk_sys);
        gr       = game_color_t'(rand_bits(GAME_COLORW));
        gg       = game_color_t'(rand_bits(GAME_COLORW));
        gb       = game_color_t'(rand_bits(GAME_COLORW));
        sr       = color_t'(rand_bits(COLORW));
        sg       = color_t'(rand_bits(COLORW));
        sb       = color_t'(rand_bits(COLORW));
        other_hs = rand_bit();
        other_vs = rand_bit();
        game_r_i   <= gr;
        game_g_i   <= gg;
        game_b_i   <= gb;
        scan2x_r_i <= sr;
        scan2x_g_i <= sg;
        scan2x_b_i <= sb;
        if (m_scan2x_dis) begin
            hs_i        <= ~hs_sel;     // native sync is active high
            vs_i        <= ~vs_sel;
            scan2x_hs_i <= other_hs;
            scan2x_vs_i <= other_vs;
            sel = '{widen_model(gr), widen_model(gg), widen_model(gb), hs_sel, vs_sel};
        end else begin
            hs_i        <= other_hs;
            vs_i        <= other_vs;
            scan2x_hs_i <= hs_sel;
            scan2x_vs_i <= vs_sel;
            sel = '{sr, sg, sb, hs_sel, vs_sel};
        end
        pixel_model(sel, exp);
        pipe.push_back(exp);
        @(negedge clk_sys);
        if (pipe.size() == 3) begin
            exp = pipe.pop_front();
            check_color("video_r", exp.r, video_r_o);
            check_color("video_g", exp.g, video_g_o);
            check_color("video_b", exp.b, video_b_o);
            check_bit("video_hs", exp.hs, video_hs_o);
            check_bit("video_vs", exp.vs, video_vs_o);
            check_bit("osd_shown", m_status[STATUS_OSD_BIT], osd_shown_o);
        end
    endtask

    task automatic config_test();
        byte_t cmd;
        word_t data;
        int    nbits;
        int    kind;
        test_name = "config_frames";
        for (int i = 0; i < CFG_FRAMES; i++) begin
            case (rand_bits(2))
                0:       cmd = CMD_JOY1;
                1:       cmd = CMD_JOY2;
                2:       cmd = CMD_STATUS;
                default: cmd = CMD_CONFIG;
            endcase
            nbits = (cmd == CMD_CONFIG) ? 16 : 40;
            data  = rand_bits(32);
            kind  = int'(rand_bits(2));
            if (kind == 2) begin
                while (cmd inside {CMD_JOY1, CMD_JOY2, CMD_STATUS, CMD_CONFIG})
                    cmd = byte_t'(rand_bits(8));
            end else if (kind == 3) begin
                nbits = 1 + int'(rand_bits(6)) % (nbits - 1);   // frame cut short
            end
            apply_frame(cmd, data, nbits);
        end
    endtask

    task automatic video_test();
        word_t st;
        test_name = "video_passthrough";
        st = rand_bits(32);
        st[STATUS_OSD_BIT] = 1'b0;
        apply_frame(CMD_STATUS, st, 40);
        for (int mode = 0; mode < 4; mode++) begin
            apply_frame(CMD_CONFIG, {6'd0, 2'(mode), 24'd0}, 16);
            repeat (VID_PIXELS) pixel_cycle(rand_bit(), rand_bit());
        end
    endtask

    task automatic osd_test();
        word_t st;
        int    len;
        test_name = "osd_shading";
        apply_frame(CMD_CONFIG, '0, 16);
        pixel_cycle(1'b0, 1'b0);    // both syncs held active clears the counters
        st = rand_bits(32);
        st[STATUS_OSD_BIT] = 1'b1;
        apply_frame(CMD_STATUS, st, 40);
        m_hpos = '0;
        m_vpos = '0;
        m_hs_d = 1'b0;
        for (int line = 0; line < OSD_LINES; line++) begin
            len = 180 + int'(rand_bits(6));
            repeat (4) pixel_cycle(1'b0, line >= 2);
            repeat (len) pixel_cycle(1'b1, line >= 2);
        end
    endtask

    task automatic audio_test();
        pcm_t samp_l;
        pcm_t samp_r;
        int   run_l;
        int   run_r;
        test_name = "audio_dac";
        run_l = 0;
        run_r = 0;
        for (int i = 0; i < AUD_CYCLES; i++) begin
            @(posedge clk_sys);
            if (run_l == 0) begin
                samp_l = pcm_t'(rand_bits(16));
                run_l  = 1 + int'(rand_bits(5));
            end
            if (run_r == 0) begin
                samp_r = pcm_t'(rand_bits(16));
                run_r  = 1 + int'(rand_bits(5));
            end
            run_l--;
            run_r--;
            snd_left_i  <= samp_l;
            snd_right_i <= samp_r;
            @(negedge clk_sys);
            check_bit("snd_pwm_left", dac_l_exp, snd_pwm_left_o);
            check_bit("snd_pwm_right", dac_r_exp, snd_pwm_right_o);
        end
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the test sequence completed");
        $display("Regression failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst_i       <= 1'b1;
        spi_sck_i   <= 1'b0;
        spi_ss_i    <= 1'b1;
        spi_di_i    <= 1'b0;
        game_r_i    <= '0;
        game_g_i    <= '0;
        game_b_i    <= '0;
        hs_i        <= 1'b0;
        vs_i        <= 1'b0;
        scan2x_r_i  <= '0;
        scan2x_g_i  <= '0;
        scan2x_b_i  <= '0;
        scan2x_hs_i <= 1'b0;
        scan2x_vs_i <= 1'b0;
        snd_left_i  <= '0;
        snd_right_i <= '0;
        repeat (3) @(posedge clk_sys);
        rst_i <= 1'b0;
        @(negedge clk_sys);
        test_name = "reset";
        check_cfg();
        check_color("video_r", '0, video_r_o);
        check_color("video_g", '0, video_g_o);
        check_color("video_b", '0, video_b_o);
        check_bit("video_hs", 1'b0, video_hs_o);
        check_bit("video_vs", 1'b0, video_vs_o);
        check_bit("snd_pwm_left", 1'b0, snd_pwm_left_o);
        check_bit("snd_pwm_right", 1'b0, snd_pwm_right_o);
        check_bit("osd_shown", 1'b0, osd_shown_o);
        config_test();
        video_test();
        osd_test();
        audio_test();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: mist_base_top.f
+incdir+verif
design/mist_pkg.sv
design/cfg_if.sv
design/spi_cfg_rx.sv
design/video_osd_mix.sv
design/rgb_to_ypbpr.sv
design/video_out.sv
design/sigma_delta_dac.sv
design/mist_base_top.sv
verif/mist_base_tb.sv
